// File: axi_lite_pkg.sv
package axi_lite_pkg;

  // AXI4-Lite bus geometry
  localparam int REG_ADDR_W   = 7;                     // 32 words, byte addressed
  localparam int DATA_W       = 32;                    // Register and stream word
  localparam int STRB_W       = DATA_W / 8;            // Byte lanes

  // Register bank geometry
  localparam int REG_CNT      = 32;                    // Decoded words
  localparam int REG_IDX_W    = $clog2(REG_CNT);       // Word index bits
  localparam int REG_RW_LAST  = 15;                    // Last writable word
  localparam int REG_RW_IDX_W = $clog2(REG_RW_LAST + 1);

  // Control words
  localparam int REG_CTRL     = 0;                     // Bit 0 enables the output
  localparam int CTRL_OUT_EN  = 0;                     // Enable bit position
  localparam int REG_PKT_LEN  = 1;                     // Beats per packet, 0 is off

  // Read-only words
  localparam int REG_MIRROR_A     = 16;                // Copy of word 2
  localparam int REG_MIRROR_B     = 17;                // Copy of word 3
  localparam int REG_MIRROR_A_SRC = 2;
  localparam int REG_MIRROR_B_SRC = 3;
  localparam int REG_LEVEL        = 18;                // Buffer fill level
  localparam int REG_SENT         = 19;                // Output beat count

  // Response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;          // Write to a read-only word

endpackage

// File: axi_stream_pkg.sv
package axi_stream_pkg;

  import axi_lite_pkg::*;                              // Shared data width

  // Beat buffer geometry
  localparam int BUF_DEPTH = 8;                        // Power of two, pointers wrap
  localparam int PTR_W     = $clog2(BUF_DEPTH);        // Read and write pointers
  localparam int LEVEL_W   = PTR_W + 1;                // Holds 0 to BUF_DEPTH

  // One stored stream beat, 37 bits
  typedef struct packed {
    logic [DATA_W-1:0] data;                           // TDATA
    logic [STRB_W-1:0] strb;                           // TSTRB
    logic              last;                           // TLAST as received
  } stream_beat_t;

endpackage

// File: axi_lite_regs.sv
`timescale 1ns/10ps

module axi_lite_regs
  import axi_lite_pkg::*;
  import axi_stream_pkg::*;
(
  input  logic                  aclk,
  input  logic                  rst_n,
  // AXI4-Lite write address and data
  input  logic [REG_ADDR_W-1:0] s_axi_lite_awaddr,
  input  logic                  s_axi_lite_awvalid,
  output logic                  s_axi_lite_awready,
  input  logic [DATA_W-1:0]     s_axi_lite_wdata,
  input  logic [STRB_W-1:0]     s_axi_lite_wstrb,
  input  logic                  s_axi_lite_wvalid,
  output logic                  s_axi_lite_wready,
  // Write response
  output logic [1:0]            s_axi_lite_bresp,
  output logic                  s_axi_lite_bvalid,
  input  logic                  s_axi_lite_bready,
  // Read address and data
  input  logic [REG_ADDR_W-1:0] s_axi_lite_araddr,
  input  logic                  s_axi_lite_arvalid,
  output logic                  s_axi_lite_arready,
  output logic [DATA_W-1:0]     s_axi_lite_rdata,
  output logic [1:0]            s_axi_lite_rresp,
  output logic                  s_axi_lite_rvalid,
  input  logic                  s_axi_lite_rready,
  // Stream path status and control
  input  logic [LEVEL_W-1:0]    level,
  input  logic [DATA_W-1:0]     sent_count,
  output logic                  out_en,
  output logic [DATA_W-1:0]     pkt_len
);

  logic [DATA_W-1:0]    bank_q [0:REG_RW_LAST];        // Writable words 0 to 15
  logic                 awready_q;                     // Shared AW and W ready
  logic                 bvalid_q;
  logic [1:0]           bresp_q;
  logic                 arready_q;
  logic                 rvalid_q;
  logic [DATA_W-1:0]    rdata_q;                       // Held until rready
  logic [REG_IDX_W-1:0] wr_idx;
  logic [REG_IDX_W-1:0] rd_idx;
  logic                 wr_hs;
  logic                 rd_hs;
  logic                 wr_ok;
  logic [DATA_W-1:0]    rd_word;

  assign wr_idx = s_axi_lite_awaddr[REG_ADDR_W-1 -: REG_IDX_W];  // Drop byte offset
  assign rd_idx = s_axi_lite_araddr[REG_ADDR_W-1 -: REG_IDX_W];
  assign wr_hs  = s_axi_lite_awvalid && awready_q;    // AW and W taken together
  assign rd_hs  = s_axi_lite_arvalid && arready_q;
  assign wr_ok  = (wr_idx <= REG_IDX_W'(REG_RW_LAST)); // Read-only above 15

  assign s_axi_lite_awready = awready_q;
  assign s_axi_lite_wready  = awready_q;
  assign s_axi_lite_bvalid  = bvalid_q;
  assign s_axi_lite_bresp   = bresp_q;
  assign s_axi_lite_arready = arready_q;
  assign s_axi_lite_rvalid  = rvalid_q;
  assign s_axi_lite_rdata   = rdata_q;
  assign s_axi_lite_rresp   = RESP_OKAY;               // Every read succeeds

  assign out_en  = bank_q[REG_CTRL][CTRL_OUT_EN];
  assign pkt_len = bank_q[REG_PKT_LEN];

  // Write channel, one ready pulse then a held response
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      awready_q <= !awready_q && !bvalid_q &&
                   s_axi_lite_awvalid && s_axi_lite_wvalid;  // Single-cycle pulse
      if (wr_hs) begin
        bvalid_q <= 1'b1;                              // Response next cycle
      end else if (bvalid_q && s_axi_lite_bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Read channel
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      arready_q <= !arready_q && !rvalid_q && s_axi_lite_arvalid;
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && s_axi_lite_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response payloads
  always_ff @(posedge aclk) begin
    if (wr_hs) begin
      bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_hs) begin
      rdata_q <= rd_word;                              // Sampled at the AR handshake
    end
  end

  // Register bank with byte enables
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i <= REG_RW_LAST; i++) begin
        bank_q[i] <= '0;
      end
    end else if (wr_hs && wr_ok) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (s_axi_lite_wstrb[b]) begin
          bank_q[wr_idx[REG_RW_IDX_W-1:0]][8*b +: 8] <= s_axi_lite_wdata[8*b +: 8];
        end
      end
    end
  end

  // Read mux over bank, mirrors and status
  always_comb begin
    rd_word = '0;                                      // Words 20 to 31 read zero
    if (rd_idx <= REG_IDX_W'(REG_RW_LAST)) begin
      rd_word = bank_q[rd_idx[REG_RW_IDX_W-1:0]];
    end else begin
      case (rd_idx)
        REG_IDX_W'(REG_MIRROR_A): rd_word = bank_q[REG_MIRROR_A_SRC];
        REG_IDX_W'(REG_MIRROR_B): rd_word = bank_q[REG_MIRROR_B_SRC];
        REG_IDX_W'(REG_LEVEL):    rd_word = DATA_W'(level);  // Zero extended
        REG_IDX_W'(REG_SENT):     rd_word = sent_count;
        default:                  rd_word = '0;
      endcase
    end
  end

endmodule

// File: axi_stream_buf.sv
`timescale 1ns/10ps

module axi_stream_buf
  import axi_lite_pkg::*;
  import axi_stream_pkg::*;
(
  input  logic               aclk,
  input  logic               rst_n,
  // AXI4-Stream slave
  input  logic [DATA_W-1:0]  s_axi_stream_tdata,
  input  logic [STRB_W-1:0]  s_axi_stream_tstrb,
  input  logic               s_axi_stream_tlast,
  input  logic               s_axi_stream_tvalid,
  output logic               s_axi_stream_tready,
  // Toward the stream master
  input  logic               buf_re,               // Pop the head beat
  output stream_beat_t       buf_data,             // Head beat
  output logic [LEVEL_W-1:0] level
);

  stream_beat_t       mem_q [0:BUF_DEPTH-1];       // Beat storage
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [LEVEL_W-1:0] level_q;                     // Fill counter
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  assign full  = (level_q == LEVEL_W'(BUF_DEPTH));
  assign empty = (level_q == '0);
  assign push  = s_axi_stream_tvalid && !full;     // Beat accepted this cycle
  assign pop   = buf_re && !empty;                 // Never pops an empty buffer

  assign s_axi_stream_tready = !full;              // Back-pressure when full
  assign level               = level_q;
  assign buf_data            = empty ? stream_beat_t'('0) : mem_q[rd_ptr_q];

  // Storage write
  always_ff @(posedge aclk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= '{data: s_axi_stream_tdata,
                           strb: s_axi_stream_tstrb,
                           last: s_axi_stream_tlast};
    end
  end

  // Pointers and fill level, push and pop may coincide
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;               // Wraps at BUF_DEPTH
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;               // Both or neither
      endcase
    end
  end

endmodule

// File: axi_stream_out.sv
`timescale 1ns/10ps

module axi_stream_out
  import axi_lite_pkg::*;
  import axi_stream_pkg::*;
(
  input  logic               aclk,
  input  logic               rst_n,
  // Buffer side
  input  stream_beat_t       buf_data,             // Head beat
  input  logic [LEVEL_W-1:0] level,
  output logic               buf_re,               // One pulse per output beat
  // Register side
  input  logic               out_en,
  input  logic [DATA_W-1:0]  pkt_len,
  output logic [DATA_W-1:0]  sent_count,
  // AXI4-Stream master
  output logic [DATA_W-1:0]  m_axi_stream_tdata,
  output logic [STRB_W-1:0]  m_axi_stream_tstrb,
  output logic               m_axi_stream_tlast,
  output logic               m_axi_stream_tvalid,
  input  logic               m_axi_stream_tready
);

  logic [DATA_W-1:0] pkt_cnt_q;                    // Beats sent in current packet
  logic [DATA_W-1:0] sent_q;                       // All handshakes, wraps
  logic              hold_q;                       // Beat offered but not taken
  logic              have_beat;
  logic              hs;
  logic              pkt_end;

  assign have_beat = (level != '0);
  // A stalled beat stays valid even if out_en drops meanwhile
  assign m_axi_stream_tvalid = (out_en || hold_q) && have_beat;
  assign hs                  = m_axi_stream_tvalid && m_axi_stream_tready;
  assign buf_re              = hs;                 // Pop exactly on the handshake

  assign pkt_end = (pkt_len != '0) && (pkt_cnt_q + 1'b1 == pkt_len);  // Forced framing

  assign m_axi_stream_tdata = buf_data.data;       // Straight from buffer head
  assign m_axi_stream_tstrb = buf_data.strb;
  assign m_axi_stream_tlast = buf_data.last || pkt_end;
  assign sent_count         = sent_q;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_cnt_q <= '0;
      sent_q    <= '0;
      hold_q    <= 1'b0;
    end else begin
      hold_q <= m_axi_stream_tvalid && !m_axi_stream_tready;
      if (hs) begin
        sent_q <= sent_q + 1'b1;
        if (m_axi_stream_tlast) begin
          pkt_cnt_q <= '0;                         // Any tlast restarts the count
        end else begin
          pkt_cnt_q <= pkt_cnt_q + 1'b1;
        end
      end
    end
  end

endmodule

// File: axi_top.sv
`timescale 1ns/10ps

module axi_top
  import axi_lite_pkg::*;
  import axi_stream_pkg::*;
(
  input  logic                  aclk,
  input  logic                  rst_n,
  // AXI4-Lite slave
  input  logic [REG_ADDR_W-1:0] s_axi_lite_awaddr,
  input  logic                  s_axi_lite_awvalid,
  output logic                  s_axi_lite_awready,
  input  logic [DATA_W-1:0]     s_axi_lite_wdata,
  input  logic [STRB_W-1:0]     s_axi_lite_wstrb,
  input  logic                  s_axi_lite_wvalid,
  output logic                  s_axi_lite_wready,
  output logic [1:0]            s_axi_lite_bresp,
  output logic                  s_axi_lite_bvalid,
  input  logic                  s_axi_lite_bready,
  input  logic [REG_ADDR_W-1:0] s_axi_lite_araddr,
  input  logic                  s_axi_lite_arvalid,
  output logic                  s_axi_lite_arready,
  output logic [DATA_W-1:0]     s_axi_lite_rdata,
  output logic [1:0]            s_axi_lite_rresp,
  output logic                  s_axi_lite_rvalid,
  input  logic                  s_axi_lite_rready,
  // AXI4-Stream slave
  input  logic [DATA_W-1:0]     s_axi_stream_tdata,
  input  logic [STRB_W-1:0]     s_axi_stream_tstrb,
  input  logic                  s_axi_stream_tlast,
  input  logic                  s_axi_stream_tvalid,
  output logic                  s_axi_stream_tready,
  // AXI4-Stream master
  output logic [DATA_W-1:0]     m_axi_stream_tdata,
  output logic [STRB_W-1:0]     m_axi_stream_tstrb,
  output logic                  m_axi_stream_tlast,
  output logic                  m_axi_stream_tvalid,
  input  logic                  m_axi_stream_tready
);

  stream_beat_t       buf_data;                    // Buffer head to master
  logic [LEVEL_W-1:0] level;                       // Fill level, also a status word
  logic               buf_re;
  logic               out_en;
  logic [DATA_W-1:0]  pkt_len;
  logic [DATA_W-1:0]  sent_count;

  axi_lite_regs regs_inst (
    .aclk               (aclk),
    .rst_n              (rst_n),
    .s_axi_lite_awaddr  (s_axi_lite_awaddr),
    .s_axi_lite_awvalid (s_axi_lite_awvalid),
    .s_axi_lite_awready (s_axi_lite_awready),
    .s_axi_lite_wdata   (s_axi_lite_wdata),
    .s_axi_lite_wstrb   (s_axi_lite_wstrb),
    .s_axi_lite_wvalid  (s_axi_lite_wvalid),
    .s_axi_lite_wready  (s_axi_lite_wready),
    .s_axi_lite_bresp   (s_axi_lite_bresp),
    .s_axi_lite_bvalid  (s_axi_lite_bvalid),
    .s_axi_lite_bready  (s_axi_lite_bready),
    .s_axi_lite_araddr  (s_axi_lite_araddr),
    .s_axi_lite_arvalid (s_axi_lite_arvalid),
    .s_axi_lite_arready (s_axi_lite_arready),
    .s_axi_lite_rdata   (s_axi_lite_rdata),
    .s_axi_lite_rresp   (s_axi_lite_rresp),
    .s_axi_lite_rvalid  (s_axi_lite_rvalid),
    .s_axi_lite_rready  (s_axi_lite_rready),
    .level              (level),
    .sent_count         (sent_count),
    .out_en             (out_en),
    .pkt_len            (pkt_len)
  );

  axi_stream_buf buf_inst (
    .aclk                (aclk),
    .rst_n               (rst_n),
    .s_axi_stream_tdata  (s_axi_stream_tdata),
    .s_axi_stream_tstrb  (s_axi_stream_tstrb),
    .s_axi_stream_tlast  (s_axi_stream_tlast),
    .s_axi_stream_tvalid (s_axi_stream_tvalid),
    .s_axi_stream_tready (s_axi_stream_tready),
    .buf_re              (buf_re),
    .buf_data            (buf_data),
    .level               (level)
  );

  axi_stream_out out_inst (
    .aclk                (aclk),
    .rst_n               (rst_n),
    .buf_data            (buf_data),
    .level               (level),
    .buf_re              (buf_re),
    .out_en              (out_en),
    .pkt_len             (pkt_len),
    .sent_count          (sent_count),
    .m_axi_stream_tdata  (m_axi_stream_tdata),
    .m_axi_stream_tstrb  (m_axi_stream_tstrb),
    .m_axi_stream_tlast  (m_axi_stream_tlast),
    .m_axi_stream_tvalid (m_axi_stream_tvalid),
    .m_axi_stream_tready (m_axi_stream_tready)
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic aclk
);

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;                      // 100 ns period
  end

endmodule

// File: axi_top_assert.sv
`timescale 1ns/10ps

module axi_top_assert
  import axi_lite_pkg::*;
  import axi_stream_pkg::*;
(
  input logic               aclk,
  input logic               rst_n,
  input logic               s_axi_lite_bvalid,
  input logic               s_axi_lite_bready,
  input logic [1:0]         s_axi_lite_bresp,
  input logic               s_axi_lite_rvalid,
  input logic               s_axi_lite_rready,
  input logic [DATA_W-1:0]  s_axi_lite_rdata,
  input logic               m_axi_stream_tvalid,
  input logic               m_axi_stream_tready,
  input logic [DATA_W-1:0]  m_axi_stream_tdata,
  input logic [STRB_W-1:0]  m_axi_stream_tstrb,
  input logic               m_axi_stream_tlast,
  input logic [LEVEL_W-1:0] level
);

  // Write response held with its code until bready
  bvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    s_axi_lite_bvalid && !s_axi_lite_bready |=>
      s_axi_lite_bvalid && $stable(s_axi_lite_bresp))
    else $error("bvalid or bresp changed before bready");

  // Read data held until rready
  rvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    s_axi_lite_rvalid && !s_axi_lite_rready |=>
      s_axi_lite_rvalid && $stable(s_axi_lite_rdata))
    else $error("rvalid or rdata changed before rready");

  // Output beat frozen while stalled
  tvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    m_axi_stream_tvalid && !m_axi_stream_tready |=>
      m_axi_stream_tvalid && $stable(m_axi_stream_tdata) &&
      $stable(m_axi_stream_tstrb) && $stable(m_axi_stream_tlast))
    else $error("output beat changed before tready");

  // Full buffer stays full until a beat leaves
  full_blocks: assert property (@(posedge aclk) disable iff (!rst_n)
    level == LEVEL_W'(BUF_DEPTH) && !(m_axi_stream_tvalid && m_axi_stream_tready) |=>
      level == LEVEL_W'(BUF_DEPTH))
    else $error("full buffer took another beat");

endmodule

bind axi_top axi_top_assert axi_top_assert_i (
  .aclk                (aclk),
  .rst_n               (rst_n),
  .s_axi_lite_bvalid   (s_axi_lite_bvalid),
  .s_axi_lite_bready   (s_axi_lite_bready),
  .s_axi_lite_bresp    (s_axi_lite_bresp),
  .s_axi_lite_rvalid   (s_axi_lite_rvalid),
  .s_axi_lite_rready   (s_axi_lite_rready),
  .s_axi_lite_rdata    (s_axi_lite_rdata),
  .m_axi_stream_tvalid (m_axi_stream_tvalid),
  .m_axi_stream_tready (m_axi_stream_tready),
  .m_axi_stream_tdata  (m_axi_stream_tdata),
  .m_axi_stream_tstrb  (m_axi_stream_tstrb),
  .m_axi_stream_tlast  (m_axi_stream_tlast),
  .level               (level)
);

// File: tb_axi_top.sv
`timescale 1ns/10ps

module tb_axi_top
  import axi_lite_pkg::*;
();

  logic                  aclk;
  logic                  rst_n;
  logic [REG_ADDR_W-1:0] s_axi_lite_awaddr;
  logic                  s_axi_lite_awvalid;
  logic                  s_axi_lite_awready;
  logic [DATA_W-1:0]     s_axi_lite_wdata;
  logic [STRB_W-1:0]     s_axi_lite_wstrb;
  logic                  s_axi_lite_wvalid;
  logic                  s_axi_lite_wready;
  logic [1:0]            s_axi_lite_bresp;
  logic                  s_axi_lite_bvalid;
  logic                  s_axi_lite_bready;
  logic [REG_ADDR_W-1:0] s_axi_lite_araddr;
  logic                  s_axi_lite_arvalid;
  logic                  s_axi_lite_arready;
  logic [DATA_W-1:0]     s_axi_lite_rdata;
  logic [1:0]            s_axi_lite_rresp;
  logic                  s_axi_lite_rvalid;
  logic                  s_axi_lite_rready;
  logic [DATA_W-1:0]     s_axi_stream_tdata;
  logic [STRB_W-1:0]     s_axi_stream_tstrb;
  logic                  s_axi_stream_tlast;
  logic                  s_axi_stream_tvalid;
  logic                  s_axi_stream_tready;
  logic [DATA_W-1:0]     m_axi_stream_tdata;
  logic [STRB_W-1:0]     m_axi_stream_tstrb;
  logic                  m_axi_stream_tlast;
  logic                  m_axi_stream_tvalid;
  logic                  m_axi_stream_tready;

  logic [31:0]           cases [0:399];            // Five words per operation
  logic [36:0]           seen_q [$];               // Output beats, data strb last
  logic [31:0]           hs_count = '0;            // Output handshakes observed
  int                    wait_limit = 200;         // Cycles or polls per wait

  tb_clk_gen clk_gen_i (.aclk(aclk));

  axi_top axi_top_i (.*);

  task automatic end_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    end_with_failure();
  endtask

  function automatic logic handshake_seen(input string which);
    if (which == "awready") return s_axi_lite_awready;
    else if (which == "bvalid") return s_axi_lite_bvalid;
    else if (which == "arready") return s_axi_lite_arready;
    else if (which == "rvalid") return s_axi_lite_rvalid;
    else return s_axi_stream_tready;               // Input stream ready
  endfunction

  // Sampled on rising edges, the handshake edge itself
  task automatic wait_high(input string which);
    int n = 0;
    do begin
      @(posedge aclk);
      n++;
    end while (!handshake_seen(which) && n < wait_limit);
    if (!handshake_seen(which)) report_timeout(which);
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] strb, input logic [31:0] resp);
    @(negedge aclk);
    s_axi_lite_awaddr  = addr[REG_ADDR_W-1:0];
    s_axi_lite_wdata   = data;
    s_axi_lite_wstrb   = strb[STRB_W-1:0];
    s_axi_lite_awvalid = 1'b1;                     // AW and W together
    s_axi_lite_wvalid  = 1'b1;
    wait_high("awready");
    compare_value("s_axi_lite_wready", 32'(s_axi_lite_wready), 32'h1);
    @(negedge aclk);
    s_axi_lite_awvalid = 1'b0;
    s_axi_lite_wvalid  = 1'b0;
    wait_high("bvalid");                           // Response first seen with bready low
    compare_value("s_axi_lite_bresp", 32'(s_axi_lite_bresp), resp);
    @(negedge aclk);
    s_axi_lite_bready = 1'b1;
    wait_high("bvalid");                           // Still held, taken on this edge
    @(negedge aclk);
    s_axi_lite_bready = 1'b0;
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
    @(negedge aclk);
    s_axi_lite_araddr  = addr[REG_ADDR_W-1:0];
    s_axi_lite_arvalid = 1'b1;
    wait_high("arready");
    @(negedge aclk);
    s_axi_lite_arvalid = 1'b0;
    wait_high("rvalid");                           // Data first seen with rready low
    @(negedge aclk);
    s_axi_lite_rready = 1'b1;
    wait_high("rvalid");
    data = s_axi_lite_rdata;                       // Taken at the R handshake
    compare_value("s_axi_lite_rresp", 32'(s_axi_lite_rresp), 32'(RESP_OKAY));
    @(negedge aclk);
    s_axi_lite_rready = 1'b0;
  endtask

  task automatic stream_send(input logic [31:0] data, input logic [31:0] strb,
                             input logic [31:0] last);
    @(negedge aclk);
    s_axi_stream_tdata  = data;
    s_axi_stream_tstrb  = strb[STRB_W-1:0];
    s_axi_stream_tlast  = last[0];
    s_axi_stream_tvalid = 1'b1;
    wait_high("s_axi_stream_tready");
    @(negedge aclk);
    s_axi_stream_tvalid = 1'b0;
  endtask

  // Offer a beat that must be refused for a number of cycles
  task automatic stall_beat(input logic [31:0] data, input logic [31:0] strb,
                            input logic [31:0] last, input logic [31:0] cycles);
    @(negedge aclk);
    s_axi_stream_tdata  = data;
    s_axi_stream_tstrb  = strb[STRB_W-1:0];
    s_axi_stream_tlast  = last[0];
    s_axi_stream_tvalid = 1'b1;
    repeat (cycles) begin
      @(posedge aclk);
      compare_value("s_axi_stream_tready", 32'(s_axi_stream_tready), 32'h0);
      compare_value("m_axi_stream_tvalid", 32'(m_axi_stream_tvalid), 32'h0);
    end
    @(negedge aclk);
    s_axi_stream_tvalid = 1'b0;                    // Withdrawn, never accepted
  endtask

  task automatic expect_beat(input logic [31:0] data, input logic [31:0] strb,
                             input logic [31:0] last);
    logic [36:0] beat;
    int          n = 0;
    while (seen_q.size() == 0 && n < wait_limit) begin
      @(posedge aclk);
      n++;
    end
    if (seen_q.size() == 0) report_timeout("an output beat");
    beat = seen_q.pop_front();                     // Arrival order
    compare_value("m_axi_stream_tdata", beat[36:5], data);
    compare_value("m_axi_stream_tstrb", 32'(beat[4:1]), strb);
    compare_value("m_axi_stream_tlast", 32'(beat[0]), last);
  endtask

  // Polls the level word over the register bus
  task automatic wait_level(input logic [31:0] want);
    logic [31:0] got;
    int          n = 0;
    reg_read(32'(REG_LEVEL * 4), got);
    while (got != want && n < wait_limit) begin
      reg_read(32'(REG_LEVEL * 4), got);
      n++;
    end
    compare_value("level", got, want);
  endtask

  // Output monitor
  always @(posedge aclk) begin
    if (rst_n && m_axi_stream_tvalid && m_axi_stream_tready) begin
      seen_q.push_back({m_axi_stream_tdata, m_axi_stream_tstrb, m_axi_stream_tlast});
      hs_count <= hs_count + 1;
    end
  end

  // Random output back-pressure
  initial begin
    m_axi_stream_tready = 1'b0;
    void'($urandom(32'hb01c));                     // Fixed seed
    forever begin
      @(negedge aclk);
      m_axi_stream_tready = ($urandom % 4) != 0;   // Ready about 3 cycles in 4
    end
  end

  initial begin
    int          idx;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] got;
    s_axi_lite_awaddr   = '0;
    s_axi_lite_awvalid  = 1'b0;
    s_axi_lite_wdata    = '0;
    s_axi_lite_wstrb    = '0;
    s_axi_lite_wvalid   = 1'b0;
    s_axi_lite_bready   = 1'b0;
    s_axi_lite_araddr   = '0;
    s_axi_lite_arvalid  = 1'b0;
    s_axi_lite_rready   = 1'b0;
    s_axi_stream_tdata  = '0;
    s_axi_stream_tstrb  = '0;
    s_axi_stream_tlast  = 1'b0;
    s_axi_stream_tvalid = 1'b0;
    rst_n               = 1'b0;
    $readmemh("axi_top_cases.txt", cases);
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;
    idx   = 0;
    while (idx < 400 && cases[idx] !== 32'hf) begin
      op = cases[idx];
      a  = cases[idx+1];
      b  = cases[idx+2];
      c  = cases[idx+3];
      d  = cases[idx+4];
      case (op)
        32'h1: reg_write(a, b, c, d);
        32'h2: begin
          reg_read(a, got);
          compare_value("s_axi_lite_rdata", got, b);
        end
        32'h3: stream_send(a, b, c);
        32'h4: expect_beat(a, b, c);
        32'h5: wait_level(a);
        32'h6: stall_beat(a, b, c, d);
        32'h7: begin
          reg_read(32'(REG_SENT * 4), got);        // Against the monitor count
          compare_value("sent_count", got, hs_count);
        end
        default: begin
          $display("Unknown operation %h at word %0d of the case file", op, idx);
          end_with_failure();
        end
      endcase
      idx += 5;
    end
    if (idx < 400) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("The case file has no end marker");
      end_with_failure();
    end
  end

endmodule

// File: axi_top_cases.txt
// op a b c d in hex. 1 reg write: addr data strb resp. 2 reg read: addr data. 3 send: data strb last
// 4 expect beat: data strb last. 5 wait level: n. 6 refused beat: data strb last cycles. 7 sent check. f end
1 08 11223344 f 0
1 08 aabbccdd 5 0
2 08 11bb33dd 0 0
1 0c cafef00d f 0
1 0c 12345678 8 0
2 0c 12fef00d 0 0
2 40 11bb33dd 0 0
2 44 12fef00d 0 0
1 50 deadbeef f 2
2 50 00000000 0 0
1 44 ffffffff f 2
2 44 12fef00d 0 0
3 a0000000 f 0 0
3 a1111111 1 0 0
3 a2222222 f 1 0
3 a3333333 3 0 0
3 a4444444 c 0 0
3 a5555555 f 0 0
3 a6666666 8 0 0
3 a7777777 f 1 0
5 8 0 0 0
6 a8888888 f 0 a
2 48 00000008 0 0
2 4c 00000000 0 0
1 00 00000001 f 0
4 a0000000 f 0 0
4 a1111111 1 0 0
4 a2222222 f 1 0
4 a3333333 3 0 0
4 a4444444 c 0 0
4 a5555555 f 0 0
4 a6666666 8 0 0
4 a7777777 f 1 0
5 0 0 0 0
7 0 0 0 0
1 04 00000003 f 0
3 b0000000 f 0 0
3 b1111111 f 0 0
3 b2222222 f 0 0
3 b3333333 f 1 0
3 b4444444 f 0 0
3 b5555555 f 0 0
3 b6666666 f 0 0
4 b0000000 f 0 0
4 b1111111 f 0 0
4 b2222222 f 1 0
4 b3333333 f 1 0
4 b4444444 f 0 0
4 b5555555 f 0 0
4 b6666666 f 1 0
5 0 0 0 0
7 0 0 0 0
2 4c 0000000f 0 0
f 0 0 0 0

// File: list.f
axi_lite_pkg.sv
axi_stream_pkg.sv
axi_lite_regs.sv
axi_stream_buf.sv
axi_stream_out.sv
axi_top.sv
tb_clk_gen.sv
axi_top_assert.sv
tb_axi_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_top
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
